// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --timescale 1ns/1ps --top-module tb_wb_xbar \
		-f wb_xbar_top.f -o tb_wb_xbar
	./obj_dir/tb_wb_xbar

clean:
	rm -rf obj_dir

// File: arbiter/wb_rr_arbiter.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module wb_rr_arbiter #(
	parameter int N_REQ = `WB_N_MST,
	localparam int ID_W = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
	input logic clk,
	input logic rstn,
	// One request bit per requester
	input logic [N_REQ-1:0] req_i,
	// Grant valid and the index of the winner
	output logic gnt_o,
	output logic [ID_W-1:0] gnt_id_o
);

	// Grant held flag
	logic gnt_q;
	// Winner index, kept after release as the rotation point
	logic [ID_W-1:0] gnt_id_q;
	// Requesters strictly above the last winner
	logic [N_REQ-1:0] above_mask;
	logic [N_REQ-1:0] masked_req;
	// Outcome of the priority search
	logic [ID_W-1:0] win_id;

	// Index of the lowest set bit, zero when none is set
	function automatic logic [ID_W-1:0] first_set(input logic [N_REQ-1:0] vec);
		logic [ID_W-1:0] id;
		id = '0;
		// Walk downwards so the lowest set bit is written last
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (vec[i]) begin
				id = ID_W'(i);
			end
		end
		return id;
	endfunction

	always_comb begin
		for (int i = 0; i < N_REQ; i++) begin
			above_mask[i] = (i > int'(gnt_id_q));
		end
	end

	assign masked_req = req_i & above_mask;

	// Search above the last winner first
	// Wrap to the lowest request when nothing is pending above it
	assign win_id = (|masked_req) ? first_set(masked_req) : first_set(req_i);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
			gnt_id_q <= '0;
		end else if (!gnt_q) begin
			// Idle, take the next winner
			if (|req_i) begin
				gnt_q <= 1'b1;
				gnt_id_q <= win_id;
			end
		end else if (!req_i[gnt_id_q]) begin
			// Winner dropped its request, release on this edge
			gnt_q <= 1'b0;
		end
	end

	assign gnt_o = gnt_q;
	assign gnt_id_o = gnt_id_q;

endmodule

`default_nettype wire

// File: common/wb_xbar_defines.svh
`ifndef WB_XBAR_DEFINES_SVH
`define WB_XBAR_DEFINES_SVH

// Wishbone bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
// One select bit per data byte
`define WB_SEL_W 4

// Crossbar dimensions
`define WB_N_MST 4
`define WB_N_SLV 3
// External slaves plus the decode-error target
`define WB_N_TGT 4

// Slave address windows, base and limit both inclusive
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_0FFF
`define WB_S1_BASE 32'h0000_1000
`define WB_S1_LIMIT 32'h0000_1FFF
`define WB_S2_BASE 32'h0001_0000
`define WB_S2_LIMIT 32'h0001_FFFF

// Target index of the decode-error responder
`define WB_ERR_TGT 3

`endif

// File: common/wb_xbar_pkg.sv
`default_nettype none

`include "wb_xbar_defines.svh"

package wb_xbar_pkg;

	// Master index
	// Also the source select of the request switch
	typedef logic [$clog2(`WB_N_MST)-1:0] mst_id_t;

	// Target index, error target included
	typedef logic [$clog2(`WB_N_TGT)-1:0] tgt_id_t;

	// Request fields routed from a master to a target
	// stb already carries the master's cyc
	typedef struct packed {
		logic [`WB_ADDR_W-1:0] adr;
		logic [`WB_DATA_W-1:0] dat_w;
		logic [`WB_SEL_W-1:0] sel;
		logic we;
		logic stb;
	} wb_req_t;

	// Response fields routed from a target back to its master
	typedef struct packed {
		logic [`WB_DATA_W-1:0] dat_r;
		logic ack;
		logic err;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: test/tb_wb_slave_mem.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module tb_wb_slave_mem #(
	parameter int WAIT_CYCLES = 0,
	parameter logic [`WB_ADDR_W-1:0] BASE_ADR = '0
) (
	input logic clk,
	input logic rstn,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic [`WB_ADDR_W-1:0] adr_i,
	input logic [`WB_DATA_W-1:0] dat_i,
	input logic [`WB_SEL_W-1:0] sel_i,
	output logic [`WB_DATA_W-1:0] dat_o,
	output logic ack_o,
	output logic err_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// 64 words, word index from address bits 7 to 2
	logic [`WB_DATA_W-1:0] mem [64];
	// Wait states spent on the current cycle
	int wait_cnt;
	logic [5:0] word;

	assign word = adr_i[7:2];
	// This model never signals an error
	assign err_o = 1'b0;

	always @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
			dat_o <= '0;
			wait_cnt <= 0;
			// Fill with the inverted byte address of each word
			for (int i = 0; i < 64; i++) begin
				mem[i] <= ~(BASE_ADR + 32'(i * 4));
			end
		end else if (ack_o) begin
			// Single pulse, then wait for stb to drop
			ack_o <= 1'b0;
			wait_cnt <= 0;
		end else if (cyc_i && stb_i) begin
			if (wait_cnt == WAIT_CYCLES) begin
				ack_o <= 1'b1;
				dat_o <= mem[word];
				if (we_i) begin
					for (int b = 0; b < `WB_SEL_W; b++) begin
						if (sel_i[b]) begin
							mem[word][8*b +: 8] <= dat_i[8*b +: 8];
						end
					end
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end else begin
			wait_cnt <= 0;
		end
	end

endmodule

`default_nettype wire

// File: test/tb_wb_xbar.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module tb_wb_xbar;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rstn;
	// Master side of the DUT
	logic m_cyc_i [`WB_N_MST];
	logic m_stb_i [`WB_N_MST];
	logic m_we_i [`WB_N_MST];
	logic [`WB_ADDR_W-1:0] m_adr_i [`WB_N_MST];
	logic [`WB_DATA_W-1:0] m_dat_i [`WB_N_MST];
	logic [`WB_SEL_W-1:0] m_sel_i [`WB_N_MST];
	logic [`WB_DATA_W-1:0] m_dat_o [`WB_N_MST];
	logic m_ack_o [`WB_N_MST];
	logic m_err_o [`WB_N_MST];
	// Slave side of the DUT
	logic s_cyc_o [`WB_N_SLV];
	logic s_stb_o [`WB_N_SLV];
	logic s_we_o [`WB_N_SLV];
	logic [`WB_ADDR_W-1:0] s_adr_o [`WB_N_SLV];
	logic [`WB_DATA_W-1:0] s_dat_o [`WB_N_SLV];
	logic [`WB_SEL_W-1:0] s_sel_o [`WB_N_SLV];
	logic [`WB_DATA_W-1:0] s_dat_i [`WB_N_SLV];
	logic s_ack_i [`WB_N_SLV];
	logic s_err_i [`WB_N_SLV];

	// One entry per line of the data file
	int op_round [$];
	int op_mst [$];
	logic op_we [$];
	logic [`WB_ADDR_W-1:0] op_adr [$];
	logic [`WB_DATA_W-1:0] op_wdat [$];
	logic [`WB_SEL_W-1:0] op_sel [$];
	logic [`WB_DATA_W-1:0] op_rdat [$];
	logic op_err [$];
	int n_rounds = 0;
	// Expected slave contents by byte address, built from completed writes
	logic [`WB_DATA_W-1:0] ref_mem [logic [`WB_ADDR_W-1:0]];
	int cycles = 0;
	int limit = 0;

	always #5 clk = ~clk;

	wb_xbar_top dut0 (
		.clk(clk),
		.rstn(rstn),
		.m_cyc_i(m_cyc_i),
		.m_stb_i(m_stb_i),
		.m_we_i(m_we_i),
		.m_adr_i(m_adr_i),
		.m_dat_i(m_dat_i),
		.m_sel_i(m_sel_i),
		.m_dat_o(m_dat_o),
		.m_ack_o(m_ack_o),
		.m_err_o(m_err_o),
		.s_cyc_o(s_cyc_o),
		.s_stb_o(s_stb_o),
		.s_we_o(s_we_o),
		.s_adr_o(s_adr_o),
		.s_dat_o(s_dat_o),
		.s_sel_o(s_sel_o),
		.s_dat_i(s_dat_i),
		.s_ack_i(s_ack_i),
		.s_err_i(s_err_i)
	);

	// Slave s gets s extra wait states
	for (genvar s = 0; s < `WB_N_SLV; s++) begin : g_slv
		tb_wb_slave_mem #(
			.WAIT_CYCLES(s),
			.BASE_ADR(s == 0 ? `WB_S0_BASE : (s == 1 ? `WB_S1_BASE : `WB_S2_BASE))
		) u_mem (
			.clk(clk),
			.rstn(rstn),
			.cyc_i(s_cyc_o[s]),
			.stb_i(s_stb_o[s]),
			.we_i(s_we_o[s]),
			.adr_i(s_adr_o[s]),
			.dat_i(s_dat_o[s]),
			.sel_i(s_sel_o[s]),
			.dat_o(s_dat_i[s]),
			.ack_o(s_ack_i[s]),
			.err_o(s_err_i[s])
		);
	end

	// Budget of 40 cycles per round plus 20 for reset and drain
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Test failures found");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", limit);
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "Wrong value in %s", name);
		end
	endtask

	// Byte lanes with sel set take the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Windows written out from the memory map
	function automatic logic in_window(input int s, input logic [31:0] adr);
		case (s)
			0: return adr[31:12] == 20'h00000;
			1: return adr[31:12] == 20'h00001;
			default: return adr[31:16] == 16'h0001;
		endcase
	endfunction

	task automatic load_ops();
		int fd;
		int rd;
		int mt;
		int we;
		int er;
		logic [31:0] adr;
		logic [31:0] wdat;
		logic [31:0] rdat;
		logic [3:0] sel;
		string line;
		fd = $fopen("test/wb_xbar_input.txt", "r");
		if (fd == 0) begin
			$display("Test failures found");
			$fatal(1, "Could not open the input data file");
		end
		while ($fgets(line, fd) > 0) begin
			// Skip the column notes and blank lines
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				if ($sscanf(line, "%d %d %d %h %h %h %h %d",
						rd, mt, we, adr, wdat, sel, rdat, er) == 8) begin
					op_round.push_back(rd);
					op_mst.push_back(mt);
					op_we.push_back(we != 0);
					op_adr.push_back(adr);
					op_wdat.push_back(wdat);
					op_sel.push_back(sel);
					op_rdat.push_back(rdat);
					op_err.push_back(er != 0);
					if (rd + 1 > n_rounds) begin
						n_rounds = rd + 1;
					end
				end
			end
		end
		$fclose(fd);
	endtask

	// Every routed slave strobe must carry the fields of an active master
	// whose address lies in that slave's window
	task automatic check_slaves();
		int src;
		for (int s = 0; s < `WB_N_SLV; s++) begin
			if (s_cyc_o[s] || s_stb_o[s]) begin
				// Addresses within one round are distinct, so the address names the master
				src = -1;
				for (int m = `WB_N_MST - 1; m >= 0; m--) begin
					if (m_cyc_i[m] && m_stb_i[m] && m_adr_i[m] == s_adr_o[s]) begin
						src = m;
					end
				end
				if (src < 0) begin
					$display("Test failures found");
					$fatal(1, "Slave %0d was strobed at address %h by no active master",
						s, s_adr_o[s]);
				end
				check_val($sformatf("slave %0d cyc", s), 32'(1), 32'(s_cyc_o[s]));
				check_val($sformatf("slave %0d stb", s), 32'(1), 32'(s_stb_o[s]));
				check_val($sformatf("slave %0d window", s), 32'(1),
					32'(in_window(s, m_adr_i[src])));
				check_val($sformatf("slave %0d we", s), 32'(m_we_i[src]), 32'(s_we_o[s]));
				check_val($sformatf("slave %0d write data", s), m_dat_i[src], s_dat_o[s]);
				check_val($sformatf("slave %0d sel", s), 32'(m_sel_i[src]),
					32'(s_sel_o[s]));
			end
		end
	endtask

	task automatic check_idle(input string name);
		for (int m = 0; m < `WB_N_MST; m++) begin
			check_val({name, " ack"}, 32'(0), 32'(m_ack_o[m]));
			check_val({name, " err"}, 32'(0), 32'(m_err_o[m]));
		end
		for (int s = 0; s < `WB_N_SLV; s++) begin
			check_val({name, " slave stb"}, 32'(0), 32'(s_stb_o[s]));
			check_val({name, " slave cyc"}, 32'(0), 32'(s_cyc_o[s]));
		end
	endtask

	// Called on the falling edge where the master sees ack or err
	task automatic finish_op(input int r, input int i);
		int m;
		string tag;
		logic [31:0] old_w;
		m = op_mst[i];
		tag = $sformatf("round %0d master %0d", r, m);
		check_val({tag, " err"}, 32'(op_err[i]), 32'(m_err_o[m]));
		check_val({tag, " ack"}, 32'(!op_err[i]), 32'(m_ack_o[m]));
		if (!op_we[i]) begin
			check_val({tag, " read data"}, op_rdat[i], m_dat_o[m]);
			if (!op_err[i] && ref_mem.exists(op_adr[i])) begin
				check_val({tag, " merged data"}, ref_mem[op_adr[i]], m_dat_o[m]);
			end
		end else if (!op_err[i]) begin
			old_w = ref_mem.exists(op_adr[i]) ? ref_mem[op_adr[i]] : '0;
			ref_mem[op_adr[i]] = merge_bytes(old_w, op_wdat[i], op_sel[i]);
		end
		// Drop the cycle right away, stb stays low at least one cycle
		m_cyc_i[m] = 1'b0;
		m_stb_i[m] = 1'b0;
		m_we_i[m] = 1'b0;
	endtask

	// Launch all lines of one round together, wait for each to end
	task automatic run_round(input int r);
		int idx [`WB_N_MST];
		logic pending [`WB_N_MST];
		int n_pending;
		int m;
		n_pending = 0;
		for (int k = 0; k < `WB_N_MST; k++) begin
			pending[k] = 1'b0;
		end
		@(negedge clk);
		check_slaves();
		for (int i = 0; i < op_round.size(); i++) begin
			if (op_round[i] == r) begin
				m = op_mst[i];
				idx[m] = i;
				pending[m] = 1'b1;
				n_pending++;
				m_cyc_i[m] = 1'b1;
				m_stb_i[m] = 1'b1;
				m_we_i[m] = op_we[i];
				m_adr_i[m] = op_adr[i];
				m_dat_i[m] = op_wdat[i];
				m_sel_i[m] = op_sel[i];
			end
		end
		while (n_pending > 0) begin
			@(negedge clk);
			check_slaves();
			for (int k = 0; k < `WB_N_MST; k++) begin
				if (pending[k] && (m_ack_o[k] || m_err_o[k])) begin
					finish_op(r, idx[k]);
					pending[k] = 1'b0;
					n_pending--;
				end
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		for (int m = 0; m < `WB_N_MST; m++) begin
			m_cyc_i[m] = 1'b0;
			m_stb_i[m] = 1'b0;
			m_we_i[m] = 1'b0;
			m_adr_i[m] = '0;
			m_dat_i[m] = '0;
			m_sel_i[m] = '0;
		end
		load_ops();
		limit = 40 * n_rounds + 20;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		repeat (2) @(negedge clk);
		check_idle("after reset");
		for (int r = 0; r < n_rounds; r++) begin
			run_round(r);
		end
		repeat (2) @(negedge clk);
		check_idle("after last round");
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/wb_xbar_input.txt
# round master we addr wdata sel exp_rdata exp_err
# addr wdata sel exp_rdata in hex, the other columns decimal
0 0 1 00001100 0a1a2a3a f 00000000 0
0 1 1 00001104 0b1b2b3b f 00000000 0
0 2 1 00001108 0c1c2c3c f 00000000 0
0 3 1 0000110c 0d1d2d3d f 00000000 0
1 0 1 00000100 a0a1a2a3 f 00000000 0
1 1 1 00000104 b0b1b2b3 f 00000000 0
1 2 1 00000108 c0c1c2c3 f 00000000 0
1 3 1 0000010c d0d1d2d3 f 00000000 0
2 0 1 00010100 a0000001 f 00000000 0
2 1 1 00010104 b0000002 f 00000000 0
2 2 1 00010108 c0000003 f 00000000 0
2 3 1 0001010c d0000004 f 00000000 0
3 0 0 00000100 00000000 f a0a1a2a3 0
3 1 0 00000104 00000000 f b0b1b2b3 0
3 2 0 00000108 00000000 f c0c1c2c3 0
3 3 0 0000010c 00000000 f d0d1d2d3 0
4 0 0 00001100 00000000 f 0a1a2a3a 0
4 1 0 00001104 00000000 f 0b1b2b3b 0
4 2 0 00001108 00000000 f 0c1c2c3c 0
4 3 0 0000110c 00000000 f 0d1d2d3d 0
5 0 0 00010100 00000000 f a0000001 0
5 1 0 00010104 00000000 f b0000002 0
5 2 0 00010108 00000000 f c0000003 0
5 3 0 0001010c 00000000 f d0000004 0
6 0 1 00000100 11223344 5 00000000 0
6 1 0 00001104 00000000 f 0b1b2b3b 0
6 2 0 00010108 00000000 f c0000003 0
6 3 0 00008000 00000000 f 00000000 1
7 0 0 00000100 00000000 f a022a244 0
7 1 0 00002000 00000000 f 00000000 1
7 3 1 00020000 deadbeef f 00000000 1

// File: verilog/wb_decode_err.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module wb_decode_err (
	input logic clk,
	input logic rstn,
	// Request routed to the error target
	input wb_xbar_pkg::wb_req_t req_i,
	// Error response, never an ack
	output wb_xbar_pkg::wb_rsp_t rsp_o
);

	// Error strobe
	logic err_q;

	// Rise one edge after stb, fall on the next edge
	// The route closes on the err edge, so stb is gone before a second pulse
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_i.stb && !err_q;
		end
	end

	// Unmapped reads return zero
	assign rsp_o.dat_r = '0;
	assign rsp_o.ack = 1'b0;
	assign rsp_o.err = err_q;

endmodule

`default_nettype wire

// File: verilog/wb_xbar_ctrl.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module wb_xbar_ctrl (
	input logic clk,
	input logic rstn,
	// Master request qualifiers and address
	input logic m_cyc_i [`WB_N_MST],
	input logic m_stb_i [`WB_N_MST],
	input logic [`WB_ADDR_W-1:0] m_adr_i [`WB_N_MST],
	// Response as routed back to each master
	input logic m_ack_i [`WB_N_MST],
	input logic m_err_i [`WB_N_MST],
	// One request vector per target arbiter
	output logic [`WB_N_MST-1:0] arb_req_o [`WB_N_TGT],
	input logic arb_gnt_i [`WB_N_TGT],
	input wb_xbar_pkg::mst_id_t arb_gnt_id_i [`WB_N_TGT],
	// Request switch control, per target
	output wb_xbar_pkg::mst_id_t tgt_sel_o [`WB_N_TGT],
	output logic tgt_en_o [`WB_N_TGT],
	// Response switch control, per master
	output wb_xbar_pkg::tgt_id_t mst_sel_o [`WB_N_MST],
	output logic mst_en_o [`WB_N_MST]
);

	import wb_xbar_pkg::*;

	// Per master cycle state
	logic busy_q [`WB_N_MST];
	// Target latched at the start of the cycle
	tgt_id_t tgt_q [`WB_N_MST];

	// Window decode
	// Anything outside the three windows goes to the error target
	function automatic tgt_id_t decode_tgt(input logic [`WB_ADDR_W-1:0] adr);
		tgt_id_t tgt;
		if (adr >= `WB_S0_BASE && adr <= `WB_S0_LIMIT) begin
			tgt = tgt_id_t'(0);
		end else if (adr >= `WB_S1_BASE && adr <= `WB_S1_LIMIT) begin
			tgt = tgt_id_t'(1);
		end else if (adr >= `WB_S2_BASE && adr <= `WB_S2_LIMIT) begin
			tgt = tgt_id_t'(2);
		end else begin
			tgt = tgt_id_t'(`WB_ERR_TGT);
		end
		return tgt;
	endfunction

	for (genvar m = 0; m < `WB_N_MST; m++) begin : g_mst
		// Idle to busy on cyc and stb, busy to idle on the routed ack or err
		always_ff @(posedge clk) begin
			if (!rstn) begin
				busy_q[m] <= 1'b0;
				tgt_q[m] <= tgt_id_t'(`WB_ERR_TGT);
			end else if (!busy_q[m]) begin
				if (m_cyc_i[m] && m_stb_i[m]) begin
					busy_q[m] <= 1'b1;
					// Address is stable for the whole cycle, decode once
					tgt_q[m] <= decode_tgt(m_adr_i[m]);
				end
			end else if (m_ack_i[m] || m_err_i[m]) begin
				busy_q[m] <= 1'b0;
			end
		end

		// Response comes from the latched target
		assign mst_sel_o[m] = tgt_q[m];

		// Only while this master owns the grant of its target
		assign mst_en_o[m] = busy_q[m] && arb_gnt_i[tgt_q[m]] &&
			(arb_gnt_id_i[tgt_q[m]] == mst_id_t'(m));
	end

	for (genvar t = 0; t < `WB_N_TGT; t++) begin : g_tgt
		// A master requests a target for as long as it is busy on it
		always_comb begin
			for (int m = 0; m < `WB_N_MST; m++) begin
				arb_req_o[t][m] = busy_q[m] && (tgt_q[m] == tgt_id_t'(t));
			end
		end

		assign tgt_sel_o[t] = arb_gnt_id_i[t];

		// Grant alone is not enough
		// The grant lingers one cycle after the winner finishes,
		// so the winner must still be busy on this very target
		assign tgt_en_o[t] = arb_gnt_i[t] && busy_q[arb_gnt_id_i[t]] &&
			(tgt_q[arb_gnt_id_i[t]] == tgt_id_t'(t));
	end

endmodule

`default_nettype wire

// File: verilog/wb_xbar_switch.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module wb_xbar_switch #(
	parameter type payload_t = wb_xbar_pkg::wb_req_t,
	parameter int N_SRC = `WB_N_MST,
	parameter int N_DST = `WB_N_TGT,
	localparam int SEL_W = (N_SRC > 1) ? $clog2(N_SRC) : 1
) (
	// All source payloads
	input payload_t src_i [N_SRC],
	// Source index per destination
	input logic [SEL_W-1:0] sel_i [N_DST],
	// Route valid per destination
	input logic en_i [N_DST],
	// Routed payload per destination
	output payload_t dst_o [N_DST]
);

	// Select valid, guards a source count that is not a power of two
	logic sel_ok [N_DST];

	for (genvar d = 0; d < N_DST; d++) begin : g_dst
		assign sel_ok[d] = (int'(sel_i[d]) < N_SRC);

		// Disabled destination sees all zero, so no stray stb or ack
		assign dst_o[d] = (en_i[d] && sel_ok[d]) ? src_i[sel_i[d]] : payload_t'('0);
	end

endmodule

`default_nettype wire

// File: verilog/wb_xbar_top.sv
`default_nettype none

`include "wb_xbar_defines.svh"

module wb_xbar_top (
	input logic clk,
	input logic rstn,
	// Master side
	input logic m_cyc_i [`WB_N_MST],
	input logic m_stb_i [`WB_N_MST],
	input logic m_we_i [`WB_N_MST],
	input logic [`WB_ADDR_W-1:0] m_adr_i [`WB_N_MST],
	input logic [`WB_DATA_W-1:0] m_dat_i [`WB_N_MST],
	input logic [`WB_SEL_W-1:0] m_sel_i [`WB_N_MST],
	output logic [`WB_DATA_W-1:0] m_dat_o [`WB_N_MST],
	output logic m_ack_o [`WB_N_MST],
	output logic m_err_o [`WB_N_MST],
	// Slave side
	output logic s_cyc_o [`WB_N_SLV],
	output logic s_stb_o [`WB_N_SLV],
	output logic s_we_o [`WB_N_SLV],
	output logic [`WB_ADDR_W-1:0] s_adr_o [`WB_N_SLV],
	output logic [`WB_DATA_W-1:0] s_dat_o [`WB_N_SLV],
	output logic [`WB_SEL_W-1:0] s_sel_o [`WB_N_SLV],
	input logic [`WB_DATA_W-1:0] s_dat_i [`WB_N_SLV],
	input logic s_ack_i [`WB_N_SLV],
	input logic s_err_i [`WB_N_SLV]
);

	import wb_xbar_pkg::*;

	// Payloads on both sides of the two switches
	wb_req_t mst_req [`WB_N_MST];
	wb_req_t tgt_req [`WB_N_TGT];
	wb_rsp_t tgt_rsp [`WB_N_TGT];
	wb_rsp_t mst_rsp [`WB_N_MST];

	// Arbitration
	logic [`WB_N_MST-1:0] arb_req [`WB_N_TGT];
	logic arb_gnt [`WB_N_TGT];
	mst_id_t arb_gnt_id [`WB_N_TGT];

	// Switch control
	mst_id_t tgt_sel [`WB_N_TGT];
	logic tgt_en [`WB_N_TGT];
	tgt_id_t mst_sel [`WB_N_MST];
	logic mst_en [`WB_N_MST];

	for (genvar m = 0; m < `WB_N_MST; m++) begin : g_mst
		// cyc folds into stb here
		assign mst_req[m] = '{adr: m_adr_i[m], dat_w: m_dat_i[m], sel: m_sel_i[m],
			we: m_we_i[m], stb: m_cyc_i[m] & m_stb_i[m]};
		assign m_dat_o[m] = mst_rsp[m].dat_r;
		assign m_ack_o[m] = mst_rsp[m].ack;
		assign m_err_o[m] = mst_rsp[m].err;
	end

	for (genvar s = 0; s < `WB_N_SLV; s++) begin : g_slv
		// Slave cyc follows the routed stb
		assign s_cyc_o[s] = tgt_req[s].stb;
		assign s_stb_o[s] = tgt_req[s].stb;
		assign s_we_o[s] = tgt_req[s].we;
		assign s_adr_o[s] = tgt_req[s].adr;
		assign s_dat_o[s] = tgt_req[s].dat_w;
		assign s_sel_o[s] = tgt_req[s].sel;
		assign tgt_rsp[s] = '{dat_r: s_dat_i[s], ack: s_ack_i[s], err: s_err_i[s]};
	end

	wb_xbar_ctrl u_ctrl (
		.clk(clk),
		.rstn(rstn),
		.m_cyc_i(m_cyc_i),
		.m_stb_i(m_stb_i),
		.m_adr_i(m_adr_i),
		.m_ack_i(m_ack_o),
		.m_err_i(m_err_o),
		.arb_req_o(arb_req),
		.arb_gnt_i(arb_gnt),
		.arb_gnt_id_i(arb_gnt_id),
		.tgt_sel_o(tgt_sel),
		.tgt_en_o(tgt_en),
		.mst_sel_o(mst_sel),
		.mst_en_o(mst_en)
	);

	// One arbiter per target, error target included
	for (genvar t = 0; t < `WB_N_TGT; t++) begin : g_arb
		wb_rr_arbiter #(
			.N_REQ(`WB_N_MST)
		) u_arb (
			.clk(clk),
			.rstn(rstn),
			.req_i(arb_req[t]),
			.gnt_o(arb_gnt[t]),
			.gnt_id_o(arb_gnt_id[t])
		);
	end

	// Masters to targets
	wb_xbar_switch #(
		.payload_t(wb_req_t),
		.N_SRC(`WB_N_MST),
		.N_DST(`WB_N_TGT)
	) u_req_sw (
		.src_i(mst_req),
		.sel_i(tgt_sel),
		.en_i(tgt_en),
		.dst_o(tgt_req)
	);

	// Targets back to masters
	wb_xbar_switch #(
		.payload_t(wb_rsp_t),
		.N_SRC(`WB_N_TGT),
		.N_DST(`WB_N_MST)
	) u_rsp_sw (
		.src_i(tgt_rsp),
		.sel_i(mst_sel),
		.en_i(mst_en),
		.dst_o(mst_rsp)
	);

	wb_decode_err u_err (
		.clk(clk),
		.rstn(rstn),
		.req_i(tgt_req[`WB_ERR_TGT]),
		.rsp_o(tgt_rsp[`WB_ERR_TGT])
	);

endmodule

`default_nettype wire

// File: wb_xbar_top.f
+incdir+common
common/wb_xbar_pkg.sv
arbiter/wb_rr_arbiter.sv
verilog/wb_xbar_ctrl.sv
verilog/wb_xbar_switch.sv
verilog/wb_decode_err.sv
verilog/wb_xbar_top.sv
test/tb_wb_slave_mem.sv
test/tb_wb_xbar.sv
